// File: common/ts_pkg.sv
`default_nettype none

package ts_pkg;

	localparam int unsigned PACKET_BYTES = 188;
	localparam int unsigned PACKET_WORDS = 47;
	localparam logic [7:0] SYNC_BYTE = 8'h47;
	localparam int unsigned PID_WIDTH = 13;

	// Field layout of the PID register word.
	typedef struct packed {
		logic [14:0] pad1;
		logic pid_enable;
		logic [2:0] pad0;
		logic [PID_WIDTH-1:0] pid;
	} pid_fields_t;

	// Software sees the raw word, the filter sees the fields.
	typedef union packed {
		logic [31:0] raw;
		pid_fields_t fields;
	} pid_reg_t;

endpackage

`default_nettype wire

// File: common/axil_pkg.sv
`default_nettype none

package axil_pkg;

	localparam int unsigned ADDR_WIDTH = 8;

	// Register map.
	localparam logic [ADDR_WIDTH-1:0] REG_CTRL = 8'h00;
	localparam logic [ADDR_WIDTH-1:0] REG_PID = 8'h04;
	localparam logic [ADDR_WIDTH-1:0] REG_PUMP = 8'h08;
	localparam logic [ADDR_WIDTH-1:0] REG_DATA_BASE = 8'h40;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: ts_capture/ts_header_matcher.sv
`timescale 1ns/10ps
`default_nettype none

module ts_header_matcher (
	input logic clk,
	input logic rst_n,
	input logic [7:0] mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	input logic [ts_pkg::PID_WIDTH-1:0] match_pid,
	input logic match_on,
	output logic wr_en,
	output logic [7:0] wr_byte_index,
	output logic [7:0] wr_byte,
	output logic pkt_done
);

	logic sync_d1;
	logic sync_d2;
	logic [7:0] data_d1;
	logic [7:0] data_d2;
	logic [7:0] data_d3;
	logic armed;
	logic [7:0] byte_count;
	logic header_hit;
	logic pid_hit;

	// The header is complete when byte 2 arrives, two beats behind the sync byte.
	assign header_hit = mpeg_valid && sync_d2 && (data_d2 == ts_pkg::SYNC_BYTE);
	assign pid_hit = ({data_d1[ts_pkg::PID_WIDTH-9:0], mpeg_data} == match_pid);

	// Bytes leave the delay line three accepted beats after they arrive.
	assign wr_en = mpeg_valid && armed;
	assign wr_byte_index = byte_count;
	assign wr_byte = data_d3;
	assign pkt_done = wr_en && (byte_count == 8'(ts_pkg::PACKET_BYTES - 1));

	always_ff @(posedge clk) begin
		if (mpeg_valid) begin
			data_d1 <= mpeg_data;
			data_d2 <= data_d1;
			data_d3 <= data_d2;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
			armed <= 1'b0;
			byte_count <= 8'd0;
		end else if (mpeg_valid) begin
			sync_d1 <= mpeg_sync;
			sync_d2 <= sync_d1;
			if (wr_en) begin
				if (pkt_done)
					armed <= 1'b0;
				byte_count <= byte_count + 8'd1;
			end
			// A fresh header wins over the tail of the previous packet.
			if (header_hit) begin
				armed <= pid_hit && match_on;
				byte_count <= 8'd0;
			end
		end
	end

endmodule

`default_nettype wire

// File: ts_capture/ts_packet_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module ts_packet_buffer (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input logic [7:0] wr_byte_index,
	input logic [7:0] wr_byte,
	input logic pkt_done,
	input logic [5:0] rd_index,
	output logic [31:0] rd_data
);

	logic [31:0] bank_mem [0:1][0:ts_pkg::PACKET_WORDS-1];
	logic bank_wr;
	logic bank_rd;

	// The bank not being filled holds the last complete packet.
	assign bank_rd = ~bank_wr;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bank_wr <= 1'b0;
		end else if (pkt_done) begin
			bank_wr <= ~bank_wr;
		end
	end

	// Byte k lands in lane k mod 4 of word k div 4, lane 0 lowest.
	always_ff @(posedge clk) begin
		if (wr_en)
			bank_mem[bank_wr][wr_byte_index[7:2]][8*wr_byte_index[1:0] +: 8] <= wr_byte;
	end

	always_ff @(posedge clk) begin
		rd_data <= bank_mem[bank_rd][rd_index];
	end

endmodule

`default_nettype wire

// File: ts_capture/ts_pid_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module ts_pid_monitor (
	input logic clk,
	input logic rst_n,
	input logic match_enable,
	input logic [31:0] pid_word,
	input logic pump_start,
	input logic [7:0] mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	output logic pump_done,
	output logic out_valid,
	output logic [5:0] out_index,
	output logic [31:0] out_data,
	output logic [7:0] captured_count
);

	ts_pkg::pid_reg_t pid_reg;
	logic match_on;
	logic wr_en;
	logic [7:0] wr_byte_index;
	logic [7:0] wr_byte;
	logic pkt_done;
	logic rd_active;
	logic [5:0] rd_index;
	logic [31:0] rd_data;

	assign pid_reg.raw = pid_word;
	assign match_on = match_enable && pid_reg.fields.pid_enable;

	// ************************************************************
	// Capture path
	// ************************************************************

	ts_header_matcher i_ts_header_matcher (
		.clk(clk),
		.rst_n(rst_n),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.match_pid(pid_reg.fields.pid),
		.match_on(match_on),
		.wr_en(wr_en),
		.wr_byte_index(wr_byte_index),
		.wr_byte(wr_byte),
		.pkt_done(pkt_done)
	);

	ts_packet_buffer i_ts_packet_buffer (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(wr_en),
		.wr_byte_index(wr_byte_index),
		.wr_byte(wr_byte),
		.pkt_done(pkt_done),
		.rd_index(rd_index),
		.rd_data(rd_data)
	);

	always_ff @(posedge clk) begin
		if (!rst_n)
			captured_count <= 8'd0;
		else if (pkt_done)
			captured_count <= captured_count + 8'd1;
	end

	// ************************************************************
	// Pump engine
	// ************************************************************

	// Read data returns one cycle after the index, so index and valid follow it.
	assign out_data = rd_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_active <= 1'b0;
			rd_index <= 6'd0;
			out_valid <= 1'b0;
			out_index <= 6'd0;
			pump_done <= 1'b0;
		end else begin
			out_valid <= rd_active;
			out_index <= rd_index;
			if (pump_start && !rd_active && !out_valid) begin
				rd_active <= 1'b1;
				rd_index <= 6'd0;
				pump_done <= 1'b0;
			end else if (rd_active) begin
				if (rd_index == 6'(ts_pkg::PACKET_WORDS - 1))
					rd_active <= 1'b0;
				else
					rd_index <= rd_index + 6'd1;
			end
			if (out_valid && (out_index == 6'(ts_pkg::PACKET_WORDS - 1)))
				pump_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/axil_monitor_regs.sv
`timescale 1ns/10ps
`default_nettype none

module axil_monitor_regs (
	input logic clk,
	input logic rst_n,
	input logic [axil_pkg::ADDR_WIDTH-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input logic bready,
	input logic [axil_pkg::ADDR_WIDTH-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic rvalid,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	input logic rready,
	output logic match_enable,
	output logic [31:0] pid_word,
	output logic pump_start,
	input logic pump_done,
	input logic out_valid,
	input logic [5:0] out_index,
	input logic [31:0] out_data,
	input logic [7:0] captured_count
);

	logic wr_accept;
	logic [31:0] window [0:ts_pkg::PACKET_WORDS-1];
	logic [axil_pkg::ADDR_WIDTH-1:0] win_offset;
	logic [5:0] win_index;
	logic in_window;
	logic [31:0] rd_word;
	logic rd_err;

	// Address and data channels are accepted in the same cycle.
	assign awready = wr_accept;
	assign wready = wr_accept;

	// ************************************************************
	// Write channel
	// ************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_accept <= 1'b0;
			bvalid <= 1'b0;
			match_enable <= 1'b0;
			pid_word <= 32'd0;
			pump_start <= 1'b0;
		end else begin
			wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
			pump_start <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_accept) begin
				bvalid <= 1'b1;
				case (awaddr)
					axil_pkg::REG_CTRL: match_enable <= wdata[0];
					axil_pkg::REG_PID: pid_word <= wdata;
					axil_pkg::REG_PUMP: pump_start <= wdata[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			case (awaddr)
				axil_pkg::REG_CTRL, axil_pkg::REG_PID, axil_pkg::REG_PUMP:
					bresp <= axil_pkg::RESP_OKAY;
				default:
					bresp <= axil_pkg::RESP_SLVERR;
			endcase
		end
	end

	// Words streamed out of the pump land in the readback window.
	always_ff @(posedge clk) begin
		if (out_valid)
			window[out_index] <= out_data;
	end

	// ************************************************************
	// Read channel
	// ************************************************************

	assign win_offset = araddr - axil_pkg::REG_DATA_BASE;
	assign win_index = win_offset[7:2];
	assign in_window = (araddr >= axil_pkg::REG_DATA_BASE) && (win_offset[1:0] == 2'b00)
		&& (win_index < 6'(ts_pkg::PACKET_WORDS));

	always_comb begin
		rd_word = 32'd0;
		rd_err = 1'b0;
		case (araddr)
			axil_pkg::REG_CTRL: rd_word = {31'd0, match_enable};
			axil_pkg::REG_PID: rd_word = pid_word;
			axil_pkg::REG_PUMP: rd_word = {16'd0, captured_count, 7'd0, pump_done};
			default: begin
				if (in_window)
					rd_word = window[win_index];
				else
					rd_err = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (arready)
				rvalid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (arready) begin
			rdata <= rd_word;
			rresp <= rd_err ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
		end
	end

endmodule

`default_nettype wire

// File: design/ts_monitor_top.sv
`timescale 1ns/10ps
`default_nettype none

module ts_monitor_top (
	input logic clk,
	input logic rst_n,
	input logic [axil_pkg::ADDR_WIDTH-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input logic bready,
	input logic [axil_pkg::ADDR_WIDTH-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic rvalid,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	input logic rready,
	input logic [7:0] mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync
);

	logic match_enable;
	logic [31:0] pid_word;
	logic pump_start;
	logic pump_done;
	logic out_valid;
	logic [5:0] out_index;
	logic [31:0] out_data;
	logic [7:0] captured_count;

	axil_monitor_regs i_axil_monitor_regs (
		.clk(clk),
		.rst_n(rst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.match_enable(match_enable),
		.pid_word(pid_word),
		.pump_start(pump_start),
		.pump_done(pump_done),
		.out_valid(out_valid),
		.out_index(out_index),
		.out_data(out_data),
		.captured_count(captured_count)
	);

	ts_pid_monitor i_ts_pid_monitor (
		.clk(clk),
		.rst_n(rst_n),
		.match_enable(match_enable),
		.pid_word(pid_word),
		.pump_start(pump_start),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.pump_done(pump_done),
		.out_valid(out_valid),
		.out_index(out_index),
		.out_data(out_data),
		.captured_count(captured_count)
	);

endmodule

`default_nettype wire

// File: verification/tb_ts_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ts_monitor;

	localparam int TIMEOUT_CYCLES = 200;
	localparam logic [12:0] PID_A = 13'h1A3C;
	localparam logic [12:0] PID_B = 13'h0B21;

	logic clk;
	logic rst_n;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic [1:0] bresp;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rready;
	logic [7:0] mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;

	int seed;
	int error_count;
	int checks_done;
	int test_count;
	int failed_tests;
	int errors_at_start;
	string test_name;
	logic [7:0] pkt_bytes [0:187];
	logic [31:0] exp_words [0:46];
	logic [31:0] read_words [0:46];
	logic [7:0] exp_count;
	logic [31:0] word;
	logic [1:0] resp;

	ts_monitor_top i_ts_monitor_top (
		.clk(clk),
		.rst_n(rst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ************************************************************
	// Bookkeeping
	// ************************************************************

	task automatic check_equal(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks_done++;
		assert (actual === expected) else begin
			$display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout in %s: no %s within %0d cycles", test_name, what, TIMEOUT_CYCLES);
		error_count++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = error_count;
		test_count++;
	endtask

	task automatic finish_test();
		if (error_count == errors_at_start) begin
			$display("Test %s: pass", test_name);
		end else begin
			$display("Test %s: fail", test_name);
			failed_tests++;
		end
	endtask

	// ************************************************************
	// AXI4-Lite driver
	// ************************************************************

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		output logic [1:0] wr_resp);
		int waited;
		@(posedge clk);
		#2;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			#2;
			waited++;
		end while (!(awready && wready) && waited < TIMEOUT_CYCLES);
		wr_resp = 2'bxx;
		if (!(awready && wready)) begin
			report_timeout("write address and data ready");
			awvalid = 1'b0;
			wvalid = 1'b0;
		end else begin
			// The handshake completes on the coming edge.
			@(posedge clk);
			#2;
			awvalid = 1'b0;
			wvalid = 1'b0;
			waited = 0;
			while (!bvalid && waited < TIMEOUT_CYCLES) begin
				@(posedge clk);
				#2;
				waited++;
			end
			if (!bvalid)
				report_timeout("write response");
			else
				wr_resp = bresp;
		end
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] rd_resp);
		int waited;
		@(posedge clk);
		#2;
		araddr = addr;
		arvalid = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			#2;
			waited++;
		end while (!arready && waited < TIMEOUT_CYCLES);
		data = 32'hxxxx_xxxx;
		rd_resp = 2'bxx;
		if (!arready) begin
			report_timeout("read address ready");
			arvalid = 1'b0;
		end else begin
			@(posedge clk);
			#2;
			arvalid = 1'b0;
			waited = 0;
			while (!rvalid && waited < TIMEOUT_CYCLES) begin
				@(posedge clk);
				#2;
				waited++;
			end
			if (!rvalid) begin
				report_timeout("read data");
			end else begin
				data = rdata;
				rd_resp = rresp;
			end
		end
	endtask

	// ************************************************************
	// Stream driver
	// ************************************************************

	task automatic send_byte(input logic [7:0] data, input logic sync, input logic gaps);
		logic [31:0] rnd;
		int idle;
		rnd = $random(seed);
		idle = (gaps && rnd[3:2] == 2'b00) ? int'(rnd[1:0]) : 0;
		repeat (idle) begin
			@(posedge clk);
			#2;
			mpeg_valid = 1'b0;
			mpeg_sync = 1'b0;
		end
		@(posedge clk);
		#2;
		mpeg_data = data;
		mpeg_sync = sync;
		mpeg_valid = 1'b1;
	endtask

	// Header byte 1 carries random flag bits above the PID's upper five bits.
	task automatic make_packet(input logic [12:0] pid);
		logic [31:0] rnd;
		rnd = $random(seed);
		pkt_bytes[0] = 8'h47;
		pkt_bytes[1] = {rnd[2:0], pid[12:8]};
		pkt_bytes[2] = pid[7:0];
		for (int i = 3; i < 188; i++) begin
			rnd = $random(seed);
			pkt_bytes[i] = rnd[7:0];
		end
	endtask

	task automatic send_packet(input logic gaps);
		for (int i = 0; i < 188; i++)
			send_byte(pkt_bytes[i], i == 0, gaps);
	endtask

	// The last three bytes of a packet leave the delay line only on later beats.
	task automatic flush_stream();
		for (int i = 0; i < 3; i++)
			send_byte(8'h00, 1'b0, 1'b0);
		@(posedge clk);
		#2;
		mpeg_valid = 1'b0;
	endtask

	task automatic expect_packet();
		for (int k = 0; k < 47; k++)
			exp_words[k] = {pkt_bytes[4*k+3], pkt_bytes[4*k+2], pkt_bytes[4*k+1], pkt_bytes[4*k]};
	endtask

	task automatic pump_window();
		logic [31:0] status;
		logic [1:0] r;
		int polls;
		axi_write(axil_pkg::REG_PUMP, 32'd1, r);
		check_equal("pump write response", axil_pkg::RESP_OKAY, r);
		status = 32'd0;
		polls = 0;
		while (status[0] !== 1'b1 && polls < TIMEOUT_CYCLES) begin
			axi_read(axil_pkg::REG_PUMP, status, r);
			polls++;
		end
		if (status[0] !== 1'b1)
			report_timeout("pump done");
		for (int k = 0; k < 47; k++)
			axi_read(axil_pkg::REG_DATA_BASE + 8'(4*k), read_words[k], r);
	endtask

	task automatic check_window();
		for (int k = 0; k < 47; k++)
			check_equal($sformatf("window word %0d", k), exp_words[k], read_words[k]);
	endtask

	task automatic check_count();
		axi_read(axil_pkg::REG_PUMP, word, resp);
		check_equal("captured count", 32'(exp_count), 32'(word[15:8]));
	endtask

	// ************************************************************
	// Tests
	// ************************************************************

	initial begin
		seed = 89450;
		error_count = 0;
		checks_done = 0;
		test_count = 0;
		failed_tests = 0;
		exp_count = 8'd0;
		rst_n = 1'b0;
		awaddr = 8'd0;
		awvalid = 1'b0;
		wdata = 32'd0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = 8'd0;
		arvalid = 1'b0;
		rready = 1'b1;
		mpeg_data = 8'd0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		begin_test("reset_state");
		axi_read(axil_pkg::REG_PUMP, word, resp);
		check_equal("pump done", 32'd0, 32'(word[0]));
		check_equal("captured count", 32'd0, 32'(word[15:8]));
		axi_read(axil_pkg::REG_PID, word, resp);
		check_equal("pid register", 32'd0, word);
		finish_test();

		begin_test("pid_readback");
		axi_write(axil_pkg::REG_PID, 32'h0001_0000 | 32'(PID_A), resp);
		check_equal("pid write response", axil_pkg::RESP_OKAY, resp);
		axi_read(axil_pkg::REG_PID, word, resp);
		check_equal("pid register", 32'h0001_0000 | 32'(PID_A), word);
		check_equal("pid read response", axil_pkg::RESP_OKAY, resp);
		axi_write(axil_pkg::REG_DATA_BASE, 32'h1234_5678, resp);
		check_equal("window write response", axil_pkg::RESP_SLVERR, resp);
		// Nothing is mapped between the pump register and the window.
		axi_read(8'h0C, word, resp);
		check_equal("unmapped read response", axil_pkg::RESP_SLVERR, resp);
		finish_test();

		begin_test("matched_capture");
		axi_write(axil_pkg::REG_CTRL, 32'd1, resp);
		make_packet(PID_A);
		send_packet(1'b1);
		flush_stream();
		expect_packet();
		exp_count++;
		pump_window();
		check_window();
		check_count();
		finish_test();

		begin_test("pid_filter");
		make_packet(PID_B);
		send_packet(1'b1);
		flush_stream();
		pump_window();
		check_window();
		check_count();
		finish_test();

		begin_test("enables");
		axi_write(axil_pkg::REG_CTRL, 32'd0, resp);
		make_packet(PID_A);
		send_packet(1'b0);
		flush_stream();
		check_count();
		axi_write(axil_pkg::REG_CTRL, 32'd1, resp);
		axi_write(axil_pkg::REG_PID, 32'(PID_A), resp);
		send_packet(1'b0);
		flush_stream();
		check_count();
		axi_write(axil_pkg::REG_PID, 32'h0001_0000 | 32'(PID_A), resp);
		finish_test();

		begin_test("bank_swap");
		make_packet(PID_A);
		send_packet(1'b0);
		make_packet(PID_A);
		expect_packet();
		send_packet(1'b0);
		flush_stream();
		exp_count += 8'd2;
		pump_window();
		check_window();
		check_count();
		finish_test();

		$display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
			test_count, failed_tests, checks_done, error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
common/ts_pkg.sv
common/axil_pkg.sv
ts_capture/ts_header_matcher.sv
ts_capture/ts_packet_buffer.sv
ts_capture/ts_pid_monitor.sv
design/axil_monitor_regs.sv
design/ts_monitor_top.sv
verification/tb_ts_monitor.sv

// File: Bender.yml
package:
  name: ts_monitor

sources:
  - files:
      - common/ts_pkg.sv
      - common/axil_pkg.sv
      - ts_capture/ts_header_matcher.sv
      - ts_capture/ts_packet_buffer.sv
      - ts_capture/ts_pid_monitor.sv
      - design/axil_monitor_regs.sv
      - design/ts_monitor_top.sv
  - target: test
    files:
      - verification/tb_ts_monitor.sv
